// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -sv -Wall --top-module cpuTb -f sources.f

sim:
	verilator --binary --timing --assert -sv --top-module cpuTb -f sources.f -o cpuSim
	./obj_dir/cpuSim | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input logic clk,
	aluIf.unit aluPort
);
	localparam int msb = cpuPkg::wordWidth - 1;

	logic [cpuPkg::wordWidth:0] wide; // top bit is carry or borrow
	logic ovf;

	always_comb begin
		wide = '0;
		ovf = 1'b0;
		case (aluPort.op)
			cpuPkg::aluAdd: begin
				wide = {1'b0, aluPort.a} + {1'b0, aluPort.b};
				ovf = (aluPort.a[msb] == aluPort.b[msb]) && (wide[msb] != aluPort.a[msb]);
			end
			cpuPkg::aluAdc: begin
				wide = {1'b0, aluPort.a} + {1'b0, aluPort.b}
					+ {{cpuPkg::wordWidth{1'b0}}, aluPort.carryIn};
				ovf = (aluPort.a[msb] == aluPort.b[msb]) && (wide[msb] != aluPort.a[msb]);
			end
			cpuPkg::aluSub: begin
				wide = {1'b0, aluPort.a} - {1'b0, aluPort.b}; // borrow lands in msb+1
				ovf = (aluPort.a[msb] != aluPort.b[msb]) && (wide[msb] != aluPort.a[msb]);
			end
			cpuPkg::aluAnd: wide = {1'b0, aluPort.a & aluPort.b};
			cpuPkg::aluOr: wide = {1'b0, aluPort.a | aluPort.b};
			cpuPkg::aluXor: wide = {1'b0, aluPort.a ^ aluPort.b};
			cpuPkg::aluNot: wide = {1'b0, ~aluPort.a}; // b ignored
			cpuPkg::aluShl: wide = {1'b0, aluPort.a << 1};
			cpuPkg::aluShr: wide = {1'b0, aluPort.a >> 1}; // logical
			default: wide = '0;
		endcase
	end

	// one operation registered per cycle
	always_ff @(posedge clk) begin
		aluPort.result <= wide[msb:0];
		aluPort.carry <= wide[cpuPkg::wordWidth];
		aluPort.zero <= (wide[msb:0] == '0);
		aluPort.overflow <= ovf;
	end
endmodule

// ==== aluIf.sv ====
`timescale 1ns/1ps

interface aluIf;
	logic [cpuPkg::wordWidth-1:0] a;
	logic [cpuPkg::wordWidth-1:0] b;
	logic [cpuPkg::aluOpWidth-1:0] op;
	logic carryIn; // for adc

	logic [cpuPkg::wordWidth-1:0] result; // one cycle after issue
	logic carry;
	logic zero;
	logic overflow;

	modport ctrl (
		output a, b, op, carryIn,
		input result, carry, zero, overflow
	);

	modport unit (
		input a, b, op, carryIn,
		output result, carry, zero, overflow
	);
endinterface

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit #(
	parameter int progDepth = 256,
	parameter int stackDepth = 16
) (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::wordWidth-1:0] opcode,
	input logic [cpuPkg::wordWidth-1:0] par1,
	input logic [cpuPkg::wordWidth-1:0] par2,
	input logic [cpuPkg::wordWidth-1:0] inPort,
	output logic [$clog2(progDepth)-1:0] fetchAddr,
	output logic pushEn,
	output logic [cpuPkg::wordWidth-1:0] pushData,
	output logic [$clog2(stackDepth)-1:0] stackPtr,
	input logic [cpuPkg::wordWidth-1:0] popData,
	regIf.ctrl regPort,
	aluIf.ctrl aluPort,
	output logic ioStrobe
);
	localparam int pcWidth = $clog2(progDepth);

	cpuPkg::operandWord operand;
	logic [pcWidth-1:0] pc;
	logic [pcWidth-1:0] seqPc;
	logic aluPending; // high in the writeback cycle
	logic carryFlag;
	logic zeroFlag;
	logic overflowFlag;
	logic isArith; // add, adc, sub, cmp
	logic isLogic2; // and, or, xor
	logic isUnary; // not, shl, shr
	logic isAlu;
	logic jumpTaken;
	logic [1:0] instrLen;

	assign operand = par1;
	assign fetchAddr = pc;
	assign seqPc = pc + pcWidth'(instrLen);
	assign isAlu = isArith | isLogic2 | isUnary;

	// decode
	always_comb begin
		isArith = 1'b0;
		isLogic2 = 1'b0;
		isUnary = 1'b0;
		jumpTaken = 1'b0;
		instrLen = 2'd1; // unknown opcodes fall through as nop
		aluPort.op = cpuPkg::aluAdd;
		case (opcode)
			cpuPkg::opMov3, cpuPkg::opPush, cpuPkg::opPop: instrLen = 2'd2;
			cpuPkg::opMov4: instrLen = 2'd3;
			cpuPkg::opAdd: isArith = 1'b1;
			cpuPkg::opAdc: begin
				isArith = 1'b1;
				aluPort.op = cpuPkg::aluAdc;
			end
			cpuPkg::opSub, cpuPkg::opCmp: begin
				isArith = 1'b1;
				aluPort.op = cpuPkg::aluSub;
			end
			cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor: begin
				isLogic2 = 1'b1;
				instrLen = 2'd2;
				aluPort.op = (opcode == cpuPkg::opAnd) ? cpuPkg::aluAnd
					: (opcode == cpuPkg::opOr) ? cpuPkg::aluOr : cpuPkg::aluXor;
			end
			cpuPkg::opNot, cpuPkg::opShl, cpuPkg::opShr: begin
				isUnary = 1'b1;
				instrLen = 2'd2;
				aluPort.op = (opcode == cpuPkg::opNot) ? cpuPkg::aluNot
					: (opcode == cpuPkg::opShl) ? cpuPkg::aluShl : cpuPkg::aluShr;
			end
			cpuPkg::opJmp, cpuPkg::opJc, cpuPkg::opJnc, cpuPkg::opJz, cpuPkg::opJnz: begin
				instrLen = 2'd2; // not taken skips the target word
				jumpTaken = (opcode == cpuPkg::opJmp)
					|| (opcode == cpuPkg::opJc && carryFlag)
					|| (opcode == cpuPkg::opJnc && !carryFlag)
					|| (opcode == cpuPkg::opJz && zeroFlag)
					|| (opcode == cpuPkg::opJnz && !zeroFlag);
			end
			default: ;
		endcase
	end

	// arithmetic is dx op ax, single-reg ops read the src field
	assign regPort.rdIdxA = isArith ? cpuPkg::regDx
		: (isUnary ? operand.pair.src : operand.pair.dst);
	assign regPort.rdIdxB = isArith ? cpuPkg::regAx : operand.pair.src;
	assign aluPort.a = regPort.rdDataA;
	assign aluPort.b = regPort.rdDataB;
	assign aluPort.carryIn = carryFlag;
	assign pushEn = (opcode == cpuPkg::opPush);
	assign pushData = regPort.rdDataB;

	// register writeback
	always_comb begin
		regPort.wrEn = 1'b0;
		regPort.wrIdx = operand.pair.src;
		regPort.wrData = aluPort.result;
		if (aluPending) begin
			regPort.wrEn = (opcode != cpuPkg::opCmp); // cmp only touches flags
			if (isArith)
				regPort.wrIdx = cpuPkg::regAx;
			else if (isLogic2)
				regPort.wrIdx = operand.pair.dst;
		end else begin
			case (opcode)
				cpuPkg::opMov3: begin
					regPort.wrEn = 1'b1;
					regPort.wrIdx = operand.pair.dst;
					regPort.wrData = regPort.rdDataB;
				end
				cpuPkg::opMov4: begin
					regPort.wrEn = 1'b1;
					regPort.wrData = par2;
				end
				cpuPkg::opPop: begin
					regPort.wrEn = 1'b1;
					regPort.wrData = popData;
				end
				cpuPkg::opIn: begin
					regPort.wrEn = 1'b1;
					regPort.wrIdx = cpuPkg::regDx;
					regPort.wrData = inPort;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			stackPtr <= '0;
			aluPending <= 1'b0;
			carryFlag <= 1'b0;
			zeroFlag <= 1'b0;
			overflowFlag <= 1'b0;
			ioStrobe <= 1'b0;
		end else begin
			ioStrobe <= (opcode == cpuPkg::opOut); // bx and dx stay put next cycle
			if (isAlu && !aluPending) begin
				aluPending <= 1'b1; // issue, pc holds
			end else begin
				aluPending <= 1'b0;
				pc <= jumpTaken ? operand.value[pcWidth-1:0] : seqPc;
				if (aluPending) begin
					zeroFlag <= aluPort.zero;
					if (isArith) begin
						carryFlag <= aluPort.carry;
						overflowFlag <= aluPort.overflow;
					end
				end
				if (opcode == cpuPkg::opPush)
					stackPtr <= stackPtr + 1'b1;
				else if (opcode == cpuPkg::opPop)
					stackPtr <= stackPtr - 1'b1;
			end
		end
	end
endmodule

// ==== cpuCore_checker.sv ====
`timescale 1ns/1ps

module cpuCore_checker #(
	parameter int pcWidth = 8
) (
	input logic clk,
	input logic reset,
	input logic ioStrobe,
	input logic aluPending,
	input logic [pcWidth-1:0] pc
);
	// strobe is registered, so look one edge into reset
	assert property (@(posedge clk) (!reset ##1 !reset) |-> !ioStrobe)
		else $error("ioStrobe high during reset");

	assert property (@(posedge clk) disable iff (!reset) aluPending |=> !aluPending)
		else $error("aluPending high two cycles in a row");

	// issue cycle holds the pc
	assert property (@(posedge clk) disable iff (!reset) $rose(aluPending) |-> $stable(pc))
		else $error("pc moved on alu issue");
endmodule

bind controlUnit cpuCore_checker #(.pcWidth(pcWidth)) u_checker (
	.clk(clk),
	.reset(reset),
	.ioStrobe(ioStrobe),
	.aluPending(aluPending),
	.pc(pc)
);

// ==== cpuPkg.sv ====
package cpuPkg;
	localparam int wordWidth = 16; // data and instruction word
	localparam int regIdxWidth = 2;
	localparam int aluOpWidth = 4;

	localparam logic [regIdxWidth-1:0] regAx = 2'd0;
	localparam logic [regIdxWidth-1:0] regBx = 2'd1;
	localparam logic [regIdxWidth-1:0] regCx = 2'd2;
	localparam logic [regIdxWidth-1:0] regDx = 2'd3;

	// opcode words
	localparam logic [wordWidth-1:0] opNop = 16'h0000;
	localparam logic [wordWidth-1:0] opMov3 = 16'h0007; // reg to reg
	localparam logic [wordWidth-1:0] opMov4 = 16'h0008; // immediate to reg
	localparam logic [wordWidth-1:0] opPop = 16'h0009;
	localparam logic [wordWidth-1:0] opOut = 16'h000A;
	localparam logic [wordWidth-1:0] opPush = 16'h000B;
	localparam logic [wordWidth-1:0] opAdd = 16'h000C;
	localparam logic [wordWidth-1:0] opAdc = 16'h000D;
	localparam logic [wordWidth-1:0] opSub = 16'h000E;
	localparam logic [wordWidth-1:0] opCmp = 16'h0014;
	localparam logic [wordWidth-1:0] opAnd = 16'h0015;
	localparam logic [wordWidth-1:0] opNot = 16'h0017;
	localparam logic [wordWidth-1:0] opOr = 16'h0018;
	localparam logic [wordWidth-1:0] opShl = 16'h0019;
	localparam logic [wordWidth-1:0] opShr = 16'h001A;
	localparam logic [wordWidth-1:0] opXor = 16'h001B;
	localparam logic [wordWidth-1:0] opJmp = 16'h0020;
	localparam logic [wordWidth-1:0] opJc = 16'h0021;
	localparam logic [wordWidth-1:0] opJnc = 16'h0022;
	localparam logic [wordWidth-1:0] opJz = 16'h0023;
	localparam logic [wordWidth-1:0] opJnz = 16'h0024;
	localparam logic [wordWidth-1:0] opIn = 16'h0028;

	// alu operation select
	localparam logic [aluOpWidth-1:0] aluAdd = 4'h1;
	localparam logic [aluOpWidth-1:0] aluAdc = 4'h2;
	localparam logic [aluOpWidth-1:0] aluSub = 4'h3; // also used by cmp
	localparam logic [aluOpWidth-1:0] aluAnd = 4'hA;
	localparam logic [aluOpWidth-1:0] aluNot = 4'hC;
	localparam logic [aluOpWidth-1:0] aluOr = 4'hD;
	localparam logic [aluOpWidth-1:0] aluShl = 4'hE;
	localparam logic [aluOpWidth-1:0] aluShr = 4'hF;
	localparam logic [aluOpWidth-1:0] aluXor = 4'h0;

	// first parameter word, either a plain value or a register pair
	typedef union packed {
		logic [wordWidth-1:0] value; // jump target or immediate
		struct packed {
			logic [wordWidth-2*regIdxWidth-1:0] spare;
			logic [regIdxWidth-1:0] dst; // bits 3:2
			logic [regIdxWidth-1:0] src; // bits 1:0, single-reg ops too
		} pair;
	} operandWord;
endpackage

// ==== cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
	localparam int numTests = 8;
	localparam int progDepth = 256;
	localparam int maxLen = 180; // words of generated code per test
	localparam time period = 40ns;

	logic clk;
	logic reset;
	logic progWrite;
	logic [7:0] progAddr;
	logic [15:0] progData;
	logic [15:0] inPort;
	logic [15:0] ioAddr;
	logic [15:0] ioData;
	logic ioStrobe;

	logic [31:0] lfsr = 32'h20f04b73;
	logic [15:0] prog [progDepth];
	int progLen;
	logic [15:0] expAddr [$];
	logic [15:0] expData [$];
	int got;
	int testNum;
	bit running;

	cpuTop #(.progDepth(progDepth), .stackDepth(16)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			$display("MISMATCH %s expected %h actual %h", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic emit(input logic [15:0] w);
		prog[progLen] = w;
		progLen++;
	endtask

	function automatic logic [15:0] pairWord();
		cpuPkg::operandWord w;
		w.value = '0;
		w.pair.dst = 2'(randBits(2));
		w.pair.src = 2'(randBits(2));
		return w.value;
	endfunction

	task automatic emitSimple(); // never a jump or stack op
		if (randBits(1)) begin
			emit(cpuPkg::opMov4);
			emit(pairWord());
			emit(randBits(16));
		end else
			emit(cpuPkg::opOut);
	endtask

	task automatic genProgram();
		int kind;
		int pos;
		logic [15:0] jumpOps [5];
		logic [15:0] aluOps [3];
		jumpOps = '{cpuPkg::opJmp, cpuPkg::opJc, cpuPkg::opJnc, cpuPkg::opJz, cpuPkg::opJnz};
		foreach (prog[i])
			prog[i] = cpuPkg::opNop;
		progLen = 0;
		emit(cpuPkg::opOut); // registers must read zero after reset
		while (progLen < maxLen) begin
			kind = randBits(4);
			case (kind)
				0, 1: emitSimple();
				2: begin
					emit(cpuPkg::opMov3);
					emit(pairWord());
				end
				3, 4: begin
					aluOps = '{cpuPkg::opAdd, cpuPkg::opAdc, cpuPkg::opSub};
					emit(randBits(2) == 3 ? cpuPkg::opCmp : aluOps[randBits(2) % 3]);
				end
				5: begin
					aluOps = '{cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor};
					emit(aluOps[randBits(2) % 3]);
					emit(pairWord());
				end
				6: begin
					aluOps = '{cpuPkg::opNot, cpuPkg::opShl, cpuPkg::opShr};
					emit(aluOps[randBits(2) % 3]);
					emit(pairWord());
				end
				7: begin
					emit(cpuPkg::opPush);
					emit(pairWord());
					emitSimple();
					emit(cpuPkg::opPop); // often a different register
					emit(pairWord());
				end
				8: emit(cpuPkg::opIn);
				9, 10: begin
					emit(jumpOps[randBits(3) % 5]);
					pos = progLen;
					emit(16'h0);
					emitSimple();
					if (randBits(1))
						emitSimple();
					prog[pos] = 16'(progLen); // forward, start of next instruction
				end
				default: emit(cpuPkg::opOut);
			endcase
		end
	endtask

	task automatic runModel();
		logic [15:0] r [4];
		logic [15:0] stk [16];
		logic [16:0] wide;
		logic [15:0] op;
		logic [1:0] dst;
		logic [1:0] src;
		logic c;
		logic z;
		int sp;
		int pc;
		r = '{default: '0};
		c = 1'b0;
		z = 1'b0;
		sp = 0;
		pc = 0;
		expAddr.delete();
		expData.delete();
		while (pc < progLen) begin
			op = prog[pc];
			dst = prog[pc + 1][3:2];
			src = prog[pc + 1][1:0];
			case (op)
				cpuPkg::opMov3: r[dst] = r[src];
				cpuPkg::opMov4: r[src] = prog[pc + 2];
				cpuPkg::opPush: begin
					stk[sp] = r[src];
					sp++;
				end
				cpuPkg::opPop: begin
					sp--;
					r[src] = stk[sp];
				end
				cpuPkg::opOut: begin
					expAddr.push_back(r[1]);
					expData.push_back(r[3]);
				end
				cpuPkg::opIn: r[3] = inPort;
				cpuPkg::opAdd, cpuPkg::opAdc, cpuPkg::opSub, cpuPkg::opCmp: begin
					if (op == cpuPkg::opAdd)
						wide = r[3] + r[0];
					else if (op == cpuPkg::opAdc)
						wide = r[3] + r[0] + c;
					else
						wide = {1'b0, r[3]} - {1'b0, r[0]}; // borrow on top
					c = wide[16];
					z = (wide[15:0] == 0);
					if (op != cpuPkg::opCmp)
						r[0] = wide[15:0];
				end
				cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opXor: begin
					r[dst] = (op == cpuPkg::opAnd) ? (r[dst] & r[src])
						: (op == cpuPkg::opOr) ? (r[dst] | r[src]) : (r[dst] ^ r[src]);
					z = (r[dst] == 0);
				end
				cpuPkg::opNot, cpuPkg::opShl, cpuPkg::opShr: begin
					r[src] = (op == cpuPkg::opNot) ? ~r[src]
						: (op == cpuPkg::opShl) ? (r[src] << 1) : (r[src] >> 1);
					z = (r[src] == 0);
				end
				default: ;
			endcase
			if (op == cpuPkg::opMov4)
				pc += 3;
			else if (op inside {cpuPkg::opJmp, cpuPkg::opJc, cpuPkg::opJnc,
				cpuPkg::opJz, cpuPkg::opJnz}) begin
				if (op == cpuPkg::opJmp || (op == cpuPkg::opJc && c)
					|| (op == cpuPkg::opJnc && !c) || (op == cpuPkg::opJz && z)
					|| (op == cpuPkg::opJnz && !z))
					pc = prog[pc + 1];
				else
					pc += 2;
			end else if (op inside {cpuPkg::opNop, cpuPkg::opOut, cpuPkg::opIn,
				cpuPkg::opAdd, cpuPkg::opAdc, cpuPkg::opSub, cpuPkg::opCmp})
				pc += 1;
			else
				pc += 2;
		end
	endtask

	// bx and dx are steady mid-cycle while the strobe is up
	always @(negedge clk) begin
		if (running && ioStrobe && got < expAddr.size()) begin
			check($sformatf("test%0d out%0d ioAddr", testNum, got), expAddr[got], ioAddr);
			check($sformatf("test%0d out%0d ioData", testNum, got), expData[got], ioData);
			got++;
		end
	end

	initial begin
		#((numTests * (progDepth + 20 + 3 * maxLen)) * period);
		$display("timeout, the output strobes stopped arriving");
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		reset = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		inPort = '0;
		running = 1'b0;
		for (testNum = 0; testNum < numTests; testNum++) begin
			@(posedge clk);
			running <= 1'b0;
			reset <= 1'b0;
			inPort <= randBits(16);
			@(posedge clk);
			genProgram();
			runModel();
			got = 0;
			for (int a = 0; a < progDepth; a++) begin
				@(posedge clk);
				progWrite <= 1'b1;
				progAddr <= 8'(a);
				progData <= prog[a];
			end
			@(posedge clk);
			progWrite <= 1'b0;
			repeat (4) @(posedge clk);
			@(negedge clk);
			check($sformatf("test%0d strobe in reset", testNum), 16'h0, {15'h0, ioStrobe});
			@(posedge clk);
			reset <= 1'b1;
			running <= 1'b1;
			wait (got == expAddr.size());
		end
		$display("TEST RESULT: PASS");
		$finish;
	end
endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
	parameter int progDepth = 256,
	parameter int stackDepth = 16
) (
	input logic clk,
	input logic reset,
	input logic progWrite,
	input logic [$clog2(progDepth)-1:0] progAddr,
	input logic [cpuPkg::wordWidth-1:0] progData,
	input logic [cpuPkg::wordWidth-1:0] inPort,
	output logic [cpuPkg::wordWidth-1:0] ioAddr,
	output logic [cpuPkg::wordWidth-1:0] ioData,
	output logic ioStrobe
);
	logic [$clog2(progDepth)-1:0] fetchAddr;
	logic [cpuPkg::wordWidth-1:0] opcode;
	logic [cpuPkg::wordWidth-1:0] par1;
	logic [cpuPkg::wordWidth-1:0] par2;
	logic pushEn;
	logic [cpuPkg::wordWidth-1:0] pushData;
	logic [$clog2(stackDepth)-1:0] stackPtr;
	logic [cpuPkg::wordWidth-1:0] popData;

	aluIf aluBus ();
	regIf regBus ();

	progMem #(.progDepth(progDepth)) u_progMem (
		.clk(clk),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.fetchAddr(fetchAddr),
		.opcode(opcode),
		.par1(par1),
		.par2(par2)
	);

	stackMem #(.stackDepth(stackDepth)) u_stackMem (
		.clk(clk),
		.pushEn(pushEn),
		.pushData(pushData),
		.stackPtr(stackPtr),
		.popData(popData)
	);

	regFile u_regFile (
		.clk(clk),
		.reset(reset),
		.regPort(regBus.file),
		.ioAddr(ioAddr),
		.ioData(ioData)
	);

	alu u_alu (
		.clk(clk),
		.aluPort(aluBus.unit)
	);

	controlUnit #(
		.progDepth(progDepth),
		.stackDepth(stackDepth)
	) u_controlUnit (
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.par1(par1),
		.par2(par2),
		.inPort(inPort),
		.fetchAddr(fetchAddr),
		.pushEn(pushEn),
		.pushData(pushData),
		.stackPtr(stackPtr),
		.popData(popData),
		.regPort(regBus.ctrl),
		.aluPort(aluBus.ctrl),
		.ioStrobe(ioStrobe)
	);
endmodule

// ==== progMem.sv ====
`timescale 1ns/1ps

module progMem #(
	parameter int progDepth = 256
) (
	input logic clk,
	input logic progWrite,
	input logic [$clog2(progDepth)-1:0] progAddr,
	input logic [cpuPkg::wordWidth-1:0] progData,
	input logic [$clog2(progDepth)-1:0] fetchAddr,
	output logic [cpuPkg::wordWidth-1:0] opcode,
	output logic [cpuPkg::wordWidth-1:0] par1,
	output logic [cpuPkg::wordWidth-1:0] par2
);
	localparam int addrWidth = $clog2(progDepth);

	logic [cpuPkg::wordWidth-1:0] mem [progDepth];
	logic [addrWidth-1:0] addrPar1;
	logic [addrWidth-1:0] addrPar2;

	assign addrPar1 = fetchAddr + addrWidth'(1); // wraps at the top
	assign addrPar2 = fetchAddr + addrWidth'(2);

	always_ff @(posedge clk) begin
		if (progWrite)
			mem[progAddr] <= progData; // load port
	end

	assign opcode = mem[fetchAddr];
	assign par1 = mem[addrPar1];
	assign par2 = mem[addrPar2];
endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic reset,
	regIf.file regPort,
	output logic [cpuPkg::wordWidth-1:0] ioAddr,
	output logic [cpuPkg::wordWidth-1:0] ioData
);
	logic [cpuPkg::wordWidth-1:0] ax;
	logic [cpuPkg::wordWidth-1:0] bx;
	logic [cpuPkg::wordWidth-1:0] cx;
	logic [cpuPkg::wordWidth-1:0] dx;

	function automatic logic [cpuPkg::wordWidth-1:0] readReg(
		input logic [cpuPkg::regIdxWidth-1:0] idx
	);
		case (idx)
			cpuPkg::regAx: return ax;
			cpuPkg::regBx: return bx;
			cpuPkg::regCx: return cx;
			default: return dx;
		endcase
	endfunction

	// reads follow register contents as well as the index
	always_comb begin
		regPort.rdDataA = readReg(regPort.rdIdxA);
		regPort.rdDataB = readReg(regPort.rdIdxB);
	end

	assign ioAddr = bx; // output port address
	assign ioData = dx;

	always_ff @(posedge clk) begin
		if (!reset) begin
			ax <= '0;
			bx <= '0;
			cx <= '0;
			dx <= '0;
		end else if (regPort.wrEn) begin
			case (regPort.wrIdx)
				cpuPkg::regAx: ax <= regPort.wrData;
				cpuPkg::regBx: bx <= regPort.wrData;
				cpuPkg::regCx: cx <= regPort.wrData;
				default: dx <= regPort.wrData;
			endcase
		end
	end
endmodule

// ==== regIf.sv ====
`timescale 1ns/1ps

interface regIf;
	logic [cpuPkg::regIdxWidth-1:0] rdIdxA;
	logic [cpuPkg::regIdxWidth-1:0] rdIdxB;
	logic [cpuPkg::wordWidth-1:0] rdDataA; // combinational
	logic [cpuPkg::wordWidth-1:0] rdDataB;

	logic wrEn;
	logic [cpuPkg::regIdxWidth-1:0] wrIdx;
	logic [cpuPkg::wordWidth-1:0] wrData; // taken at the clock edge

	modport ctrl (
		output rdIdxA, rdIdxB, wrEn, wrIdx, wrData,
		input rdDataA, rdDataB
	);

	modport file (
		input rdIdxA, rdIdxB, wrEn, wrIdx, wrData,
		output rdDataA, rdDataB
	);
endinterface

// ==== sources.f ====
cpuPkg.sv
aluIf.sv
regIf.sv
alu.sv
regFile.sv
progMem.sv
stackMem.sv
controlUnit.sv
cpuTop.sv
cpuCore_checker.sv
cpuTb.sv

// ==== stackMem.sv ====
`timescale 1ns/1ps

module stackMem #(
	parameter int stackDepth = 16
) (
	input logic clk,
	input logic pushEn,
	input logic [cpuPkg::wordWidth-1:0] pushData,
	input logic [$clog2(stackDepth)-1:0] stackPtr,
	output logic [cpuPkg::wordWidth-1:0] popData
);
	localparam int ptrWidth = $clog2(stackDepth);

	logic [cpuPkg::wordWidth-1:0] mem [stackDepth];
	logic [ptrWidth-1:0] topAddr;

	// stackPtr points at the next free slot
	assign topAddr = stackPtr - ptrWidth'(1);

	always_ff @(posedge clk) begin
		if (pushEn)
			mem[stackPtr] <= pushData;
	end

	assign popData = mem[topAddr]; // wraps on underflow
endmodule
